// ==== compile.f ====
logic/fp16_types_pkg.sv
logic/rotator_cfg_pkg.sv
logic/weight_loader.sv
logic/cyclic_shift_reg.sv
logic/replay_sequencer.sv
logic/weight_rotator_top.sv
verification/weight_rotator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module weight_rotator_tb -f compile.f -o weight_rotator_sim
./obj_dir/weight_rotator_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"

// ==== verification/weight_rotator_tb.sv ====
`timescale 1ns/1ps

module weight_rotator_tb;

  import fp16_types_pkg::*;
  import rotator_cfg_pkg::*;

  localparam int R_DEPTH = 8;
  localparam int RATIO   = 4;
  localparam int LIMIT   = 4000;  // cycles any single wait may take.

  logic     clk       = 1'b0;
  logic     clken     = 1'b1;
  logic     rst_n     = 1'b0;
  rot_cfg_t cfg       = '{r_addr_max: 8'd7, w_addr_max: 8'd1, passes: 8'd3};
  logic     start     = 1'b0;
  logic     load_req  = 1'b0;
  fp16_t    load_data = '0;
  logic     load_ack;
  logic     out_req;
  fp16_t    out_data;
  logic     out_ack   = 1'b0;
  logic     busy;
  logic     done;

  integer     seed         = 32'hbd9b_09e0;
  fp16_t      loaded [R_DEPTH];  // words in the order they were loaded.
  int         hs_count     = 0;  // output handshakes since reset.
  int         run_base     = 0;
  int         done_total   = 0;
  int         check_errors = 0;
  int         ctrl_errors  = 0;
  logic       ack_q        = 1'b0;
  logic [1:0] ack_delay    = 2'd0;

  weight_rotator_top #(
    .R_DEPTH (R_DEPTH),
    .RATIO   (RATIO)
  ) i_dut (
    .clk       (clk),
    .clken     (clken),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .start     (start),
    .load_req  (load_req),
    .load_data (load_data),
    .load_ack  (load_ack),
    .out_req   (out_req),
    .out_data  (out_data),
    .out_ack   (out_ack),
    .busy      (busy),
    .done      (done)
  );

  always #2 clk = ~clk;

  // a full rotation brings the ring back, so word n of a run is load word n mod ring length.
  function automatic fp16_t expected_word(int index);
    int span;
    span = int'(cfg.r_addr_max) + 1;
    return loaded[index % span];
  endfunction

  task automatic abort_run(string what);
    $display("error at %0t: %s", $time, what);
    $display("errors: %0d data, %0d control", check_errors, ctrl_errors);
    $display("Simulation failed");
    $finish;
  endtask

  // output sink with a random pause before each edge of out_ack.
  always @(posedge clk) begin
    if (!rst_n) begin
      out_ack   <= 1'b0;
      ack_delay <= 2'd0;
    end else if (ack_delay != 2'd0) begin
      ack_delay <= ack_delay - 2'd1;
    end else if (out_req && !out_ack) begin
      out_ack   <= 1'b1;
      ack_delay <= 2'($random(seed));
    end else if (!out_req && out_ack) begin
      out_ack   <= 1'b0;
      ack_delay <= 2'($random(seed));
    end
  end

  always @(negedge clk) begin : compare
    fp16_t exp_word;
    if (rst_n && out_ack && !ack_q) begin
      exp_word = expected_word(hs_count - run_base);
      assert (out_data == exp_word) else begin
        $display("mismatch at %0t: out_data got %h expected %h", $time, out_data, exp_word);
        check_errors++;
      end
      hs_count++;
    end
    if (rst_n && done) done_total++;
    ack_q = out_ack;
  end

  task automatic load_word(fp16_t word);
    int n;
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    load_req  <= 1'b1;
    load_data <= word;
    @(negedge clk);
    assert (!load_ack) else begin
      $display("load_ack was high before the loader could see load_req at %0t", $time);
      ctrl_errors++;
    end
    n = 0;
    while (!load_ack && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!load_ack) abort_run("no load_ack for a load request");
    @(posedge clk);
    load_req <= 1'b0;
    n = 0;
    while (load_ack && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (load_ack) abort_run("load_ack stayed high after load_req fell");
  endtask

  task automatic load_row();
    for (int i = 0; i < R_DEPTH; i++) begin
      loaded[i] = fp16_t'($random(seed));
      load_word(loaded[i]);
    end
    repeat (2) @(posedge clk);  // last beat reaches the ring.
  endtask

  task automatic run_replay(int words, bit probe_load);
    int n;
    int done_base;
    done_base = done_total;
    run_base  = hs_count;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (!busy && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!busy) abort_run("busy never rose after start");
    if (probe_load) begin
      @(posedge clk);
      load_req  <= 1'b1;  // held until the run is over.
      load_data <= 16'h3c00;
    end
    n = 0;
    while (done_total == done_base && n < LIMIT) begin
      @(negedge clk);
      assert (!load_ack) else begin
        $display("load_ack rose while a replay run was active at %0t", $time);
        ctrl_errors++;
      end
      n++;
    end
    if (done_total == done_base) abort_run("done never pulsed");
    n = 0;
    while (busy && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy) abort_run("busy stayed high after done");
    assert (hs_count - run_base == words) else begin
      $display("mismatch at %0t: word count got %0d expected %0d",
               $time, hs_count - run_base, words);
      ctrl_errors++;
    end
    assert (done_total - done_base == 1) else begin
      $display("done pulsed %0d times in one run", done_total - done_base);
      ctrl_errors++;
    end
  endtask

  initial begin
    int n;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!out_req && !load_ack && !busy && !done) else begin
      $display("outputs were not idle after reset");
      ctrl_errors++;
    end
    load_row();
    run_replay(24, 1'b0);
    run_replay(24, 1'b0);  // no reload in between.
    @(posedge clk);
    cfg <= '{r_addr_max: 8'd3, w_addr_max: 8'd1, passes: 8'd2};
    load_row();
    run_replay(8, 1'b1);
    n = 0;
    while (!load_ack && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!load_ack) abort_run("the held load request was never acknowledged");
    @(posedge clk);
    load_req <= 1'b0;
    n = 0;
    while (load_ack && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (load_ack) abort_run("load_ack stayed high after load_req fell");
    repeat (4) @(posedge clk);
    $display("errors: %0d data, %0d control", check_errors, ctrl_errors);
    if (check_errors + ctrl_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== logic/weight_rotator_top.sv ====
`timescale 1ns/1ps

module weight_rotator_top #(
  parameter int R_DEPTH = 8,
  parameter int RATIO   = 4
) (
  input  logic                      clk,
  input  logic                      clken,
  input  logic                      rst_n,
  input  rotator_cfg_pkg::rot_cfg_t cfg,
  input  logic                      start,
  input  logic                      load_req,
  input  fp16_types_pkg::fp16_t     load_data,
  output logic                      load_ack,
  output logic                      out_req,
  output fp16_types_pkg::fp16_t     out_data,
  input  logic                      out_ack,
  output logic                      busy,
  output logic                      done
);

  import fp16_types_pkg::*;

  fp16_t [RATIO-1:0] w_beat;
  fp16_t             m_data;
  logic              w_en;
  logic              r_en;

  weight_loader #(
    .RATIO (RATIO)
  ) i_loader (
    .clk       (clk),
    .clken     (clken),
    .rst_n     (rst_n),
    .busy      (busy),      // loading is held off during a replay run.
    .load_req  (load_req),
    .load_data (load_data),
    .load_ack  (load_ack),
    .w_beat    (w_beat),
    .w_en      (w_en)
  );

  cyclic_shift_reg #(
    .R_DEPTH (R_DEPTH),
    .RATIO   (RATIO)
  ) i_ring (
    .clk    (clk),
    .clken  (clken),
    .rst_n  (rst_n),
    .cfg    (cfg),
    .w_en   (w_en),
    .r_en   (r_en),
    .w_beat (w_beat),
    .m_data (m_data)
  );

  replay_sequencer #(
    .R_DEPTH (R_DEPTH)
  ) i_sequencer (
    .clk      (clk),
    .clken    (clken),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .start    (start),
    .m_data   (m_data),
    .r_en     (r_en),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack),
    .busy     (busy),
    .done     (done)
  );

endmodule

// ==== logic/replay_sequencer.sv ====
`timescale 1ns/1ps

module replay_sequencer #(
  parameter int R_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      clken,
  input  logic                      rst_n,
  input  rotator_cfg_pkg::rot_cfg_t cfg,
  input  logic                      start,
  input  fp16_types_pkg::fp16_t     m_data,
  output logic                      r_en,
  output logic                      out_req,
  output fp16_types_pkg::fp16_t     out_data,
  input  logic                      out_ack,
  output logic                      busy,
  output logic                      done
);

  import rotator_cfg_pkg::*;

  localparam rot_addr_t LAST_POS = rot_addr_t'(R_DEPTH - 1);

  typedef enum logic [1:0] {
    idle,
    present,
    wait_release,
    finish
  } state_t;

  state_t      state;
  rot_addr_t   pos;         // ring position currently at the head.
  pass_count_t pass;        // rotations completed in this run.
  rot_addr_t   pos_max;
  pass_count_t pass_total;

  // a ring can never be longer than the physical register.
  assign pos_max    = (cfg.r_addr_max > LAST_POS) ? LAST_POS : cfg.r_addr_max;
  assign pass_total = (cfg.passes == '0) ? pass_count_t'(1) : cfg.passes;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      pos     <= '0;
      pass    <= '0;
      r_en    <= 1'b0;
      out_req <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else if (clken) begin
      r_en <= 1'b0;
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state   <= present;
            pos     <= '0;
            pass    <= '0;
            busy    <= 1'b1;
            out_req <= 1'b1;
          end
        end
        present: begin
          if (out_ack) begin
            state   <= wait_release;
            out_req <= 1'b0;
            r_en    <= 1'b1;  // word was taken, bring the next one to the head.
            if (pos == pos_max) begin
              pos  <= '0;
              pass <= pass + 1'b1;
            end else begin
              pos <= pos + 1'b1;
            end
          end
        end
        wait_release: begin
          if (!out_ack) begin
            if (pass == pass_total) begin
              state <= finish;
              done  <= 1'b1;
            end else begin
              state   <= present;
              out_req <= 1'b1;
            end
          end
        end
        finish: begin
          state <= idle;
          busy  <= 1'b0;
        end
        default: state <= idle;
      endcase
    end
  end

  // head only moves after the ack, so the word is stable for the whole request.
  assign out_data = m_data;

endmodule

// ==== logic/cyclic_shift_reg.sv ====
`timescale 1ns/1ps

module cyclic_shift_reg #(
  parameter int R_DEPTH = 8,
  parameter int RATIO   = 4
) (
  input  logic                              clk,
  input  logic                              clken,
  input  logic                              rst_n,
  input  rotator_cfg_pkg::rot_cfg_t         cfg,
  input  logic                              w_en,
  input  logic                              r_en,
  input  fp16_types_pkg::fp16_t [RATIO-1:0] w_beat,
  output fp16_types_pkg::fp16_t             m_data
);

  import fp16_types_pkg::*;
  import rotator_cfg_pkg::*;

  fp16_t [R_DEPTH-1:0] ring;
  fp16_t [R_DEPTH-1:0] ring_next;
  logic  [R_DEPTH-1:0] w_sel;      // position is replaced by the incoming beat.
  logic  [R_DEPTH-1:0] r_sel;      // position takes part in the rotation.
  beat_addr_t          w_addr;

  // beat counter steps once per written beat and wraps at the last beat.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_addr <= '0;
    end else if (clken && w_en) begin
      w_addr <= (w_addr == cfg.w_addr_max) ? '0 : w_addr + 1'b1;
    end
  end

  for (genvar r = 0; r < R_DEPTH; r++) begin : g_pos
    fp16_t rot_src;

    assign w_sel[r] = w_en && (w_addr == beat_addr_t'(r / RATIO));
    assign r_sel[r] = r_en && (rot_addr_t'(r) <= cfg.r_addr_max);

    // the last active position closes the ring by taking the old head.
    assign rot_src = (cfg.r_addr_max == rot_addr_t'(r)) ? ring[0] : ring[(r + 1) % R_DEPTH];

    // Slices are counted from the top of the beat, so words keep their load
    // order along the ring. A write beats a rotation on the same position.
    assign ring_next[r] = w_sel[r] ? w_beat[RATIO - 1 - (r % RATIO)] : rot_src;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ring <= '0;
    end else if (clken) begin
      for (int r = 0; r < R_DEPTH; r++) begin
        if (w_sel[r] || r_sel[r]) begin
          ring[r] <= ring_next[r];
        end
      end
    end
  end

  assign m_data = ring[0];  // the head of the ring is the only read port.

endmodule

// ==== logic/weight_loader.sv ====
`timescale 1ns/1ps

module weight_loader #(
  parameter int RATIO = 4
) (
  input  logic                              clk,
  input  logic                              clken,
  input  logic                              rst_n,
  input  logic                              busy,
  input  logic                              load_req,
  input  fp16_types_pkg::fp16_t             load_data,
  output logic                              load_ack,
  output fp16_types_pkg::fp16_t [RATIO-1:0] w_beat,
  output logic                              w_en
);

  localparam int SLOT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  typedef enum logic {
    wait_req,
    wait_release
  } state_t;

  state_t            state;
  logic [SLOT_W-1:0] slot;     // words already packed into the current beat.
  logic              capture;

  // a word is taken only when no replay run is active.
  assign capture = clken && (state == wait_req) && load_req && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= wait_req;
      load_ack <= 1'b0;
      slot     <= '0;
      w_en     <= 1'b0;
    end else if (clken) begin
      w_en <= 1'b0;
      case (state)
        wait_req: begin
          if (load_req && !busy) begin
            state    <= wait_release;
            load_ack <= 1'b1;
            if (slot == SLOT_W'(RATIO - 1)) begin
              slot <= '0;
              w_en <= 1'b1;  // beat is complete once this word is in.
            end else begin
              slot <= slot + 1'b1;
            end
          end
        end
        wait_release: begin
          // the ack stays up until the source lets go of its request.
          if (!load_req) begin
            state    <= wait_req;
            load_ack <= 1'b0;
          end
        end
        default: begin
          state    <= wait_req;
          load_ack <= 1'b0;
        end
      endcase
    end
  end

  // Words shift in from the bottom, so the first word of a beat
  // ends up in the most significant slice.
  always_ff @(posedge clk) begin
    if (capture) begin
      w_beat <= {w_beat[RATIO-2:0], load_data};
    end
  end

endmodule

// ==== logic/rotator_cfg_pkg.sv ====
package rotator_cfg_pkg;

  localparam int ROT_ADDR_WIDTH   = 8;  // covers ring depths up to 256 words.
  localparam int BEAT_ADDR_WIDTH  = 8;
  localparam int PASS_COUNT_WIDTH = 8;

  typedef logic [ROT_ADDR_WIDTH-1:0]   rot_addr_t;
  typedef logic [BEAT_ADDR_WIDTH-1:0]  beat_addr_t;
  typedef logic [PASS_COUNT_WIDTH-1:0] pass_count_t;

  // run-time setup shared by the loader, the ring and the sequencer.
  typedef struct packed {
    rot_addr_t   r_addr_max;  // last ring position that takes part in the rotation.
    beat_addr_t  w_addr_max;  // last write beat before the beat counter wraps.
    pass_count_t passes;      // full rotations per run, zero behaves as one.
  } rot_cfg_t;

endpackage

// ==== logic/fp16_types_pkg.sv ====
package fp16_types_pkg;

  // IEEE 754 binary16 layout: sign, exponent, mantissa.
  localparam int FP16_EXP_WIDTH  = 5;
  localparam int FP16_MAN_WIDTH  = 10;
  localparam int FP16_SIGN_WIDTH = 1;

  localparam int FP16_WIDTH = FP16_SIGN_WIDTH + FP16_EXP_WIDTH + FP16_MAN_WIDTH;

  // the datapath never does arithmetic on a word, it only moves the raw bits.
  typedef logic [FP16_WIDTH-1:0] fp16_t;

endpackage
